// ==== common/cpu_cfg.svh ====
// Size settings for the 16-bit five-stage pipelined processor
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and instruction width
`define CPU_XLEN 16

// Architectural register count, r0 is an ordinary register
`define CPU_NREGS 8

// Memory depths, counted in 16-bit words
`define CPU_IMEM_WORDS 64
`define CPU_DMEM_WORDS 64

`endif

// ==== common/cpu_pkg.sv ====
// Opcodes, control bundle and pipeline payload types shared by all processor stages
`default_nettype none
`include "cpu_cfg.svh"

package cpu_pkg;

   typedef logic [`CPU_XLEN-1:0]               word_t;
   typedef logic [$clog2(`CPU_NREGS)-1:0]      reg_idx_t;
   typedef logic [$clog2(`CPU_IMEM_WORDS)-1:0] imem_addr_t;

   // Instruction bits 15:11
   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ALU  = 5'b11011
   } opcode_e;

   // Low four values match the ALU function field, bits 1:0
   typedef enum logic [2:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_XOR  = 3'd3,
      ALU_PASS = 3'd4   // LBI, immediate straight through
   } alu_fn_e;

   typedef enum logic [1:0] {BR_NONE, BR_EQZ, BR_NEZ, BR_JUMP} branch_e;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    alu_src_imm;
      alu_fn_e alu_fn;
      branch_e branch_kind;
      logic    halt;
   } ctrl_t;

   typedef struct packed {
      logic  valid;
      word_t pc_next;
      word_t instr;
   } if_id_t;

   typedef struct packed {
      logic     valid;
      word_t    pc_next;
      ctrl_t    ctrl;
      word_t    rs_data;
      word_t    rt_data;
      word_t    imm;
      reg_idx_t wr_sel;
   } id_ex_t;

   // pc_next rides along so writeback can report the instruction address
   typedef struct packed {
      logic     valid;
      word_t    pc_next;
      ctrl_t    ctrl;
      word_t    alu_out;
      word_t    store_data;
      reg_idx_t wr_sel;
   } ex_mem_t;

   typedef struct packed {
      logic     valid;
      word_t    pc_next;
      logic     reg_write;
      logic     mem_read;
      logic     halt;
      word_t    alu_out;
      word_t    load_data;
      reg_idx_t wr_sel;
   } mem_wb_t;

   typedef struct packed {
      word_t    pc;        // Address of the retiring instruction
      logic     reg_write;
      reg_idx_t wr_sel;
      word_t    wr_data;
      logic     halt;
   } retire_t;

endpackage

`default_nettype wire

// ==== hdl/stage_reg.sv ====
// Pipeline register between two stages, holds on stall and inserts a bubble on flush
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
   parameter type payload_t = logic
) (
   input  wire logic     clk,
   input  wire logic     arst_n,
   input  wire logic     stall,
   input  wire logic     flush,
   input  wire payload_t d,
   output payload_t      q
);

   // All-zero payload is a bubble, valid bit included
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q <= '0;
      end else if (flush) begin
         q <= '0;             // Flush beats stall
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

// ==== fetch/fetch_stage.sv ====
// Fetch stage with program counter, writable instruction memory and redirect handling
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module fetch_stage import cpu_pkg::*; (
   input  wire logic       clk,
   input  wire logic       arst_n,
   input  wire logic       run,
   input  wire logic       imem_wr_en,
   input  wire imem_addr_t imem_wr_addr,
   input  wire word_t      imem_wr_data,
   input  wire logic       stall,
   input  wire logic       redirect,
   input  wire word_t      redirect_pc,
   input  wire logic       halted,
   output if_id_t          if_id
);

   localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);

   word_t imem [`CPU_IMEM_WORDS];
   word_t pc;
   logic  fetch_en;

   assign fetch_en = run & ~halted;

   // Program load port, used while run is low
   always_ff @(posedge clk) begin
      if (imem_wr_en) begin
         imem[imem_wr_addr] <= imem_wr_data;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= redirect_pc;   // Redirect wins over stall
      end else if (fetch_en && !stall) begin
         pc <= pc + word_t'(2);
      end
   end

   // Byte-addressed PC, word-indexed memory
   assign if_id.valid   = fetch_en & ~redirect;
   assign if_id.pc_next = pc + word_t'(2);
   assign if_id.instr   = imem[pc[IMEM_AW:1]];

endmodule

`default_nettype wire

// ==== decode/decode_stage.sv ====
// Decode stage with write-through register file, control decode and immediate extension
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module decode_stage import cpu_pkg::*; (
   input  wire logic     clk,
   input  wire logic     arst_n,
   input  wire if_id_t   if_id,
   input  wire logic     wb_en,
   input  wire reg_idx_t wb_sel,
   input  wire word_t    wb_data,
   output id_ex_t        id_ex,
   output reg_idx_t      rs_sel,
   output reg_idx_t      rt_sel,
   output logic          rs_used,
   output logic          rt_used,
   output logic          err
);

   word_t    regs [`CPU_NREGS];
   word_t    instr;
   reg_idx_t rd_sel;
   ctrl_t    ctrl;
   word_t    imm;
   reg_idx_t wr_sel;
   logic     rs_read, rt_read;
   logic     illegal;

   assign instr  = if_id.instr;
   assign rs_sel = instr[10:8];
   assign rt_sel = instr[7:5];
   assign rd_sel = instr[4:2];

   always_ff @(posedge clk) begin
      if (wb_en) begin
         regs[wb_sel] <= wb_data;
      end
   end

   always_comb begin
      ctrl             = '0;
      ctrl.alu_fn      = ALU_ADD;
      ctrl.branch_kind = BR_NONE;
      imm              = '0;
      wr_sel           = rt_sel;
      rs_read          = 1'b0;
      rt_read          = 1'b0;
      illegal          = 1'b0;
      case (instr[15:11])
         OP_HALT: ctrl.halt = 1'b1;
         OP_NOP: ;
         OP_ADDI: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            imm              = {{(`CPU_XLEN-5){instr[4]}}, instr[4:0]};
            rs_read          = 1'b1;
         end
         OP_LBI: begin
            ctrl.reg_write   = 1'b1;
            ctrl.alu_src_imm = 1'b1;
            ctrl.alu_fn      = ALU_PASS;
            imm              = {{(`CPU_XLEN-8){instr[7]}}, instr[7:0]};
            wr_sel           = rs_sel;   // LBI writes its rs field
         end
         OP_ALU: begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_fn    = alu_fn_e'({1'b0, instr[1:0]});
            wr_sel         = rd_sel;
            rs_read        = 1'b1;
            rt_read        = 1'b1;
         end
         OP_ST, OP_LD: begin
            ctrl.mem_write   = (instr[15:11] == OP_ST);
            ctrl.mem_read    = (instr[15:11] == OP_LD);
            ctrl.reg_write   = (instr[15:11] == OP_LD);
            ctrl.alu_src_imm = 1'b1;
            imm              = {{(`CPU_XLEN-5){instr[4]}}, instr[4:0]};
            rs_read          = 1'b1;
            rt_read          = (instr[15:11] == OP_ST);   // Store data
         end
         OP_BEQZ, OP_BNEZ: begin
            ctrl.branch_kind = (instr[15:11] == OP_BEQZ) ? BR_EQZ : BR_NEZ;
            imm              = {{(`CPU_XLEN-8){instr[7]}}, instr[7:0]};
            rs_read          = 1'b1;
         end
         OP_J: begin
            ctrl.branch_kind = BR_JUMP;
            imm              = {{(`CPU_XLEN-11){instr[10]}}, instr[10:0]};
         end
         default: illegal = 1'b1;
      endcase
   end

   assign rs_used = if_id.valid & rs_read;
   assign rt_used = if_id.valid & rt_read;

   // Writeback value is visible in the same cycle
   always_comb begin
      id_ex.valid   = if_id.valid & ~illegal;
      id_ex.pc_next = if_id.pc_next;
      id_ex.ctrl    = ctrl;
      id_ex.rs_data = (wb_en && wb_sel == rs_sel) ? wb_data : regs[rs_sel];
      id_ex.rt_data = (wb_en && wb_sel == rt_sel) ? wb_data : regs[rt_sel];
      id_ex.imm     = imm;
      id_ex.wr_sel  = wr_sel;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         err <= 1'b0;
      end else if (if_id.valid && illegal) begin
         err <= 1'b1;   // Sticky until reset
      end
   end

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
// Execute stage with operand select, ALU, zero test and branch resolution
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
   input  wire id_ex_t id_ex,
   output ex_mem_t     ex_mem,
   output logic        redirect,
   output word_t       redirect_pc
);

   word_t opa, opb;
   word_t alu_out;
   logic  rs_zero;
   logic  taken;

   assign opa = id_ex.rs_data;
   assign opb = id_ex.ctrl.alu_src_imm ? id_ex.imm : id_ex.rt_data;

   always_comb begin
      case (id_ex.ctrl.alu_fn)
         ALU_ADD:  alu_out = opa + opb;
         ALU_SUB:  alu_out = opa - opb;
         ALU_AND:  alu_out = opa & opb;
         ALU_XOR:  alu_out = opa ^ opb;
         ALU_PASS: alu_out = opb;
         default:  alu_out = '0;
      endcase
   end

   // Branches test rs only
   assign rs_zero = (opa == '0);

   always_comb begin
      case (id_ex.ctrl.branch_kind)
         BR_EQZ:  taken = rs_zero;
         BR_NEZ:  taken = ~rs_zero;
         BR_JUMP: taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign redirect    = id_ex.valid & taken;
   assign redirect_pc = id_ex.pc_next + id_ex.imm;   // Offset from PC+2

   always_comb begin
      ex_mem.valid      = id_ex.valid;
      ex_mem.pc_next    = id_ex.pc_next;
      ex_mem.ctrl       = id_ex.ctrl;
      ex_mem.alu_out    = alu_out;
      ex_mem.store_data = id_ex.rt_data;
      ex_mem.wr_sel     = id_ex.wr_sel;
   end

endmodule

`default_nettype wire

// ==== hdl/hazard_unit.sv ====
// Hazard detection, stalls the front end on register dependences and squashes on redirect
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
   input  wire reg_idx_t rs_sel,
   input  wire reg_idx_t rt_sel,
   input  wire logic     rs_used,
   input  wire logic     rt_used,
   input  wire id_ex_t   id_ex_q,
   input  wire ex_mem_t  ex_mem_q,
   input  wire logic     redirect,
   output logic          stall_front,
   output logic          flush_if_id,
   output logic          flush_id_ex
);

   logic ex_writes, mem_writes;
   logic rs_hit, rt_hit;
   logic dep;

   // Writeback is covered by the register file write-through
   assign ex_writes  = id_ex_q.valid & id_ex_q.ctrl.reg_write;
   assign mem_writes = ex_mem_q.valid & ex_mem_q.ctrl.reg_write;

   assign rs_hit = rs_used & ((ex_writes  && id_ex_q.wr_sel  == rs_sel) ||
                              (mem_writes && ex_mem_q.wr_sel == rs_sel));
   assign rt_hit = rt_used & ((ex_writes  && id_ex_q.wr_sel  == rt_sel) ||
                              (mem_writes && ex_mem_q.wr_sel == rt_sel));
   assign dep    = rs_hit | rt_hit;

   assign stall_front = dep & ~redirect;      // Squashed instructions never stall
   assign flush_if_id = redirect;
   assign flush_id_ex = redirect | dep;       // Bubble into execute

endmodule

`default_nettype wire

// ==== hdl/data_memory.sv ====
// Data memory with synchronous write and combinational read, builds the writeback payload
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module data_memory import cpu_pkg::*; (
   input  wire logic    clk,
   input  wire ex_mem_t ex_mem_q,
   output mem_wb_t      mem_wb
);

   localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

   word_t                mem [`CPU_DMEM_WORDS];
   logic [DMEM_AW-1:0]   addr;

   // alu_out is a byte address, bit 0 ignored
   assign addr = ex_mem_q.alu_out[DMEM_AW:1];

   always_ff @(posedge clk) begin
      if (ex_mem_q.valid && ex_mem_q.ctrl.mem_write && !ex_mem_q.ctrl.halt) begin
         mem[addr] <= ex_mem_q.store_data;
      end
   end

   always_comb begin
      mem_wb.valid     = ex_mem_q.valid;
      mem_wb.pc_next   = ex_mem_q.pc_next;
      mem_wb.reg_write = ex_mem_q.ctrl.reg_write;
      mem_wb.mem_read  = ex_mem_q.ctrl.mem_read;
      mem_wb.halt      = ex_mem_q.ctrl.halt;
      mem_wb.alu_out   = ex_mem_q.alu_out;
      mem_wb.load_data = mem[addr];
      mem_wb.wr_sel    = ex_mem_q.wr_sel;
   end

endmodule

`default_nettype wire

// ==== hdl/cpu_top.sv ====
// Five-stage 16-bit processor top with writeback select, retire port and halt tracking
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
   input  wire logic       clk,
   input  wire logic       arst_n,
   input  wire logic       run,
   input  wire logic       imem_wr_en,
   input  wire imem_addr_t imem_wr_addr,
   input  wire word_t      imem_wr_data,
   output logic            retire_valid,
   output retire_t         retire,
   output logic            halted,
   output logic            err
);

   if_id_t   if_id_d, if_id_q;
   id_ex_t   id_ex_d, id_ex_q;
   ex_mem_t  ex_mem_d, ex_mem_q;
   mem_wb_t  mem_wb_d, mem_wb_q;
   logic     redirect;
   word_t    redirect_pc;
   logic     stall_front, flush_if_id, flush_id_ex;
   reg_idx_t rs_sel, rt_sel;
   logic     rs_used, rt_used;
   logic     halt_in_ex, fetch_hold;
   logic     wb_en;
   word_t    wb_data;

   // HALT in execute squashes its followers like a taken branch
   assign halt_in_ex = id_ex_q.valid & id_ex_q.ctrl.halt;
   assign fetch_hold = halted | halt_in_ex |
                       (ex_mem_q.valid & ex_mem_q.ctrl.halt) |
                       (mem_wb_q.valid & mem_wb_q.halt);

   fetch_stage fetch0 (.clk, .arst_n, .run, .imem_wr_en, .imem_wr_addr, .imem_wr_data,
                       .stall(stall_front), .redirect, .redirect_pc,
                       .halted(fetch_hold), .if_id(if_id_d));

   stage_reg #(.payload_t(if_id_t)) if_id_reg (.clk, .arst_n, .stall(stall_front),
      .flush(flush_if_id), .d(if_id_d), .q(if_id_q));

   decode_stage decode0 (.clk, .arst_n, .if_id(if_id_q), .wb_en, .wb_sel(mem_wb_q.wr_sel),
                         .wb_data, .id_ex(id_ex_d), .rs_sel, .rt_sel, .rs_used, .rt_used,
                         .err);

   hazard_unit hazard0 (.rs_sel, .rt_sel, .rs_used, .rt_used, .id_ex_q, .ex_mem_q,
                        .redirect(redirect | halt_in_ex), .stall_front, .flush_if_id,
                        .flush_id_ex);

   stage_reg #(.payload_t(id_ex_t)) id_ex_reg (.clk, .arst_n, .stall(1'b0),
      .flush(flush_id_ex), .d(id_ex_d), .q(id_ex_q));

   execute_stage execute0 (.id_ex(id_ex_q), .ex_mem(ex_mem_d), .redirect, .redirect_pc);

   stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (.clk, .arst_n, .stall(1'b0),
      .flush(1'b0), .d(ex_mem_d), .q(ex_mem_q));

   data_memory memory0 (.clk, .ex_mem_q, .mem_wb(mem_wb_d));

   stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (.clk, .arst_n, .stall(1'b0),
      .flush(1'b0), .d(mem_wb_d), .q(mem_wb_q));

   // Writeback select
   assign wb_data = mem_wb_q.mem_read ? mem_wb_q.load_data : mem_wb_q.alu_out;
   assign wb_en   = mem_wb_q.valid & mem_wb_q.reg_write;

   assign retire_valid      = mem_wb_q.valid;
   assign retire.pc         = mem_wb_q.pc_next - word_t'(2);
   assign retire.reg_write  = mem_wb_q.reg_write;
   assign retire.wr_sel     = mem_wb_q.wr_sel;
   assign retire.wr_data    = wb_data;
   assign retire.halt       = mem_wb_q.halt;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         halted <= 1'b0;
      end else if (mem_wb_q.valid && mem_wb_q.halt) begin
         halted <= 1'b1;   // Stays set until reset
      end
   end

endmodule

`default_nettype wire

// ==== testbench/cpu_checker.sv ====
// Retire port monitor that compares each completed instruction in order with the expected records
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import cpu_pkg::*; (
   input  wire logic    clk,
   input  wire logic    arst_n,
   input  wire logic    retire_valid,
   input  wire retire_t retire,
   input  wire logic    halted,
   input  wire logic    err
);

   string   exp_name [$];
   retire_t exp_rec [$];
   int      next_idx     = 0;
   int      errors       = 0;
   logic    err_seen     = 1'b0;
   logic    halt_retired = 1'b0;   // HALT has left writeback
   logic    halted_bad   = 1'b0;

   task automatic expect_retire(input string name, input retire_t rec);
      exp_name.push_back(name);
      exp_rec.push_back(rec);
   endtask

   // Destination fields only matter when a register is written
   function automatic retire_t mask_unwritten(input retire_t r);
      retire_t m;
      m = r;
      if (!r.reg_write) begin
         m.wr_sel  = '0;
         m.wr_data = '0;
      end
      return m;
   endfunction

   function automatic string format_record(input retire_t r);
      return $sformatf("pc=%h we=%b sel=%0d data=%h halt=%b",
                       r.pc, r.reg_write, r.wr_sel, r.wr_data, r.halt);
   endfunction

   // Retire port is settled at the negative edge
   always @(negedge clk) begin
      // halted follows the HALT retirement by one cycle and then holds
      if (arst_n && !halted_bad) begin
         if (halted && !halt_retired) begin
            $display("halted rose before the HALT instruction retired");
            errors++;
            halted_bad = 1'b1;
         end else if (halt_retired && !halted) begin
            $display("halted is low after the HALT instruction retired");
            errors++;
            halted_bad = 1'b1;
         end
      end
      if (arst_n && retire_valid) begin
         if (halted) begin
            $display("Instruction at pc %h retired after halted rose", retire.pc);
            errors++;
         end
         if (next_idx >= exp_rec.size()) begin
            $display("Unexpected retirement past the last expected record: %s",
                     format_record(retire));
            errors++;
         end else begin
            if (mask_unwritten(retire) != mask_unwritten(exp_rec[next_idx])) begin
               $display("[FAIL] %s: expected %s, actual %s", exp_name[next_idx],
                        format_record(mask_unwritten(exp_rec[next_idx])),
                        format_record(mask_unwritten(retire)));
               errors++;
            end
            next_idx++;
         end
         if (retire.halt) begin
            halt_retired = 1'b1;
         end
      end
      if (arst_n && err && !err_seen) begin
         $display("Decode raised err on an illegal opcode at %0t", $time);
         errors++;
         err_seen = 1'b1;
      end
   end

   task automatic final_report(output int total);
      int missing;
      missing = exp_rec.size() - next_idx;
      if (missing > 0) begin
         $display("%0d expected retirements never happened, the first in test %s",
                  missing, exp_name[next_idx]);
      end
      total = errors + ((missing > 0) ? missing : 0);
   endtask

endmodule

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
// Testbench top for the five-stage processor, loads the program from the stimulus file and runs it
`timescale 1ns/1ps
`default_nettype none
`include "cpu_cfg.svh"

module cpu_tb import cpu_pkg::*; ();

   localparam int    CLK_HALF     = 4;      // 8 ns period
   localparam int    RESET_CYCLES = 5;
   localparam int    RUN_TIMEOUT  = 2000;
   localparam int    DRAIN_CYCLES = 8;      // Window after halt for stray retirements
   localparam string STIM_FILE    = "testbench/cpu_stimulus.txt";

   logic       clk;
   logic       arst_n;
   logic       run;
   logic       imem_wr_en;
   imem_addr_t imem_wr_addr;
   word_t      imem_wr_data;
   logic       retire_valid;
   retire_t    retire;
   logic       halted;
   logic       err;

   int         load_errors = 0;
   int         timeouts    = 0;
   int         check_errors;
   int         n_records   = 0;

   cpu_top DUT (.clk, .arst_n, .run, .imem_wr_en, .imem_wr_addr, .imem_wr_data,
                .retire_valid, .retire, .halted, .err);

   cpu_checker retire_check (.clk, .arst_n, .retire_valid, .retire, .halted, .err);

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Packed name from the scanner, leading null bytes dropped
   function automatic string to_text(input logic [8*24-1:0] bits);
      string s;
      int    i;
      s = "";
      for (i = 23; i >= 0; i--) begin
         if (bits[8*i +: 8] != 8'h00) s = $sformatf("%s%c", s, bits[8*i +: 8]);
      end
      return s;
   endfunction

   // Each line is one program word, retiring words also carry their expected record
   task automatic load_program();
      int               fd;
      int               n;
      logic [8*256-1:0] line;
      logic [8*24-1:0]  name;
      word_t            pc, instr, data;
      int               retires, we, sel, halt;
      retire_t          rec;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file %s", STIM_FILE);
         load_errors++;
         return;
      end
      while (!$feof(fd)) begin
         line = '0;
         if ($fgets(line, fd) == 0) break;
         n = $sscanf(line, "%s %h %h %d %d %d %h %d", name, pc, instr, retires, we, sel,
                     data, halt);
         if (n != 8) continue;                  // Comment or blank line
         if (int'(pc >> 1) >= `CPU_IMEM_WORDS) begin
            $display("Program address %h lies beyond the instruction memory", pc);
            load_errors++;
            continue;
         end
         imem_wr_en   = 1'b1;
         imem_wr_addr = imem_addr_t'(pc >> 1);
         imem_wr_data = instr;
         @(posedge clk);
         #1;
         if (retires != 0) begin
            rec.pc        = pc;
            rec.reg_write = we[0];
            rec.wr_sel    = reg_idx_t'(sel);
            rec.wr_data   = data;
            rec.halt      = halt[0];
            retire_check.expect_retire(to_text(name), rec);
            n_records++;
         end
      end
      imem_wr_en = 1'b0;
      $fclose(fd);
   endtask

   task automatic wait_for_halt();
      int cycles;
      cycles = 0;
      while (!halted && cycles < RUN_TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!halted) begin
         $display("Timeout: halted did not rise within %0d cycles of run", RUN_TIMEOUT);
         timeouts++;
      end
   endtask

   initial begin
      arst_n       = 1'b0;
      run          = 1'b0;
      imem_wr_en   = 1'b0;
      imem_wr_addr = '0;
      imem_wr_data = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
      load_program();                           // Run stays low while loading
      if (load_errors == 0 && n_records == 0) begin
         $display("The stimulus file holds no expected retirements");
         load_errors++;
      end
      if (load_errors == 0) begin
         run = 1'b1;
         wait_for_halt();
         repeat (DRAIN_CYCLES) @(posedge clk);
      end
      retire_check.final_report(check_errors);
      $display("Errors: %0d check, %0d load, %0d timeout", check_errors, load_errors, timeouts);
      if (check_errors + load_errors + timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/cpu_stimulus.txt ====
# columns: test name, byte address, instruction, retires, reg write, dest reg, write data, halt
# squashed words carry retires 0, dest reg and write data count only when reg write is 1
alu_basic 0000 C105 1 1 1 0005 0
alu_basic 0002 C2FD 1 1 2 FFFD 0
alu_basic 0004 4167 1 1 3 000C 0
alu_basic 0006 4290 1 1 4 FFED 0
alu_basic 0008 D954 1 1 5 0002 0
alu_basic 000A DB39 1 1 6 0007 0
alu_basic 000C DC7E 1 1 7 000C 0
alu_basic 000E DC43 1 1 0 0010 0
dep_chain 0010 C110 1 1 1 0010 0
dep_chain 0012 4121 1 1 1 0011 0
dep_chain 0014 4121 1 1 1 0012 0
dep_chain 0016 D928 1 1 2 0024 0
dep_chain 0018 DA2D 1 1 3 0012 0
mem_rw 001A C420 1 1 4 0020 0
mem_rw 001C 8462 1 0 0 0000 0
mem_rw 001E 845E 1 0 0 0000 0
mem_rw 0020 8CA2 1 1 5 0012 0
mem_rw 0022 8CDE 1 1 6 0024 0
mem_rw 0024 DDDF 1 1 7 0036 0
branch 0026 C200 1 1 2 0000 0
branch 0028 6204 1 0 0 0000 0
branch 002A C355 0 0 0 0000 0
branch 002C C366 0 0 0 0000 0
branch 002E 6A04 1 0 0 0000 0
branch 0030 6904 1 0 0 0000 0
branch 0032 C377 0 0 0 0000 0
branch 0034 C311 0 0 0 0000 0
branch 0036 6102 1 0 0 0000 0
branch 0038 C312 1 1 3 0012 0
branch 003A 2004 1 0 0 0000 0
branch 003C C37F 0 0 0 0000 0
branch 003E C370 0 0 0 0000 0
branch 0040 439F 1 1 4 0011 0
halt 0042 0000 1 0 0 0000 1
halt 0044 0800 0 0 0 0000 0

// ==== cpu_top.f ====
+incdir+common
common/cpu_pkg.sv
hdl/stage_reg.sv
fetch/fetch_stage.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/hazard_unit.sv
hdl/data_memory.sv
hdl/cpu_top.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the processor testbench with Verilator, run it and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f cpu_top.f --top-module cpu_tb -Mdir obj_dir -o cpu_sim \
   && ./obj_dir/cpu_sim 2>&1 | tee sim.log \
   || echo "Verilator build or simulation run did not complete"
grep -qx "TESTBENCH PASSED" sim.log 2>/dev/null && echo "Result: pass" && exit 0
echo "Result: fail"
exit 1
